/* Makefile */
TOP = tb_avr_core

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -f sources.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* hw/avr_alu.sv */
module avr_alu (
	input  avr_pkg::alu_op_e  op,
	input  avr_pkg::byte_t    a,
	input  avr_pkg::byte_t    b,
	input  avr_pkg::sreg_t    sreg_in,
	output avr_pkg::byte_t    result,
	output avr_pkg::sreg_t    sreg_out
);

	logic cin;
	logic [8:0] sum;
	logic [8:0] diff;
	avr_pkg::byte_t r;

	// Carry in only for the with-carry forms
	assign cin = (op == avr_pkg::ALU_ADC || op == avr_pkg::ALU_SBC) ? sreg_in.c : 1'b0;

	// Bit 8 is carry out on add, borrow on subtract
	assign sum = {1'b0, a} + {1'b0, b} + {8'd0, cin};
	assign diff = {1'b0, a} - {1'b0, b} - {8'd0, cin};

	always_comb begin
		r = b;
		sreg_out = sreg_in; // Untouched flags pass through

		case (op)
			avr_pkg::ALU_ADD,
			avr_pkg::ALU_ADC: begin
				r = sum[7:0];
				// Carry out of bit 3
				sreg_out.h = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
				// Same-sign operands, result flipped sign
				sreg_out.v = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
				sreg_out.c = sum[8];
			end

			avr_pkg::ALU_SUB,
			avr_pkg::ALU_SBC: begin
				r = diff[7:0];
				// Borrow from bit 4
				sreg_out.h = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
				sreg_out.v = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
				sreg_out.c = diff[8];
			end

			avr_pkg::ALU_AND: begin
				r = a & b;
				sreg_out.v = 1'b0;
			end

			avr_pkg::ALU_OR: begin
				r = a | b;
				sreg_out.v = 1'b0;
			end

			avr_pkg::ALU_SWAP: r = {a[3:0], a[7:4]}; // Nibble swap, no flags

			avr_pkg::ALU_PASS_B: r = b; // LDI and the NOP path

			default: r = b;
		endcase

		// N, S and Z are common to every flag-setting op
		if (op != avr_pkg::ALU_SWAP && op != avr_pkg::ALU_PASS_B) begin
			sreg_out.n = r[7];
			sreg_out.z = (r == 8'd0);
			sreg_out.s = r[7] ^ sreg_out.v;
		end
	end

	assign result = r;

endmodule

/* hw/avr_core.sv */
module avr_core #(
	parameter avr_pkg::word_t RESET_PC = '0
) (
	input  logic              CLK,
	input  logic              RST,
	input  avr_pkg::wb_rsp_t  prog_rsp,
	output avr_pkg::wb_req_t  prog_req,
	output avr_pkg::reg_wr_t  reg_wr,
	output avr_pkg::sreg_t    sreg
);

	avr_pkg::fetch_t fetched;
	avr_pkg::redirect_t redirect;
	avr_pkg::reg_addr_t rd_addr;
	avr_pkg::reg_addr_t rr_addr;
	avr_pkg::byte_t rd_data;
	avr_pkg::byte_t rr_data;
	avr_pkg::byte_t alu_a;
	avr_pkg::byte_t alu_b;
	avr_pkg::byte_t alu_result;
	avr_pkg::alu_op_e alu_op;
	avr_pkg::sreg_t alu_sreg;

	avr_fetch #(
		.RESET_PC (RESET_PC)
	) fetch_i (
		.CLK      (CLK),
		.RST      (RST),
		.redirect (redirect),
		.prog_rsp (prog_rsp),
		.prog_req (prog_req),
		.fetched  (fetched)
	);

	avr_execute execute_i (
		.CLK        (CLK),
		.RST        (RST),
		.fetched    (fetched),
		.rd_data    (rd_data),
		.rr_data    (rr_data),
		.alu_result (alu_result),
		.alu_sreg   (alu_sreg),
		.rd_addr    (rd_addr),
		.rr_addr    (rr_addr),
		.alu_op     (alu_op),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.sreg       (sreg),
		.reg_wr     (reg_wr),
		.redirect   (redirect)
	);

	// Carry in comes from the live status register
	avr_alu alu_i (
		.op       (alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.sreg_in  (sreg),
		.result   (alu_result),
		.sreg_out (alu_sreg)
	);

	avr_regfile regfile_i (
		.CLK     (CLK),
		.RST     (RST),
		.rd_addr (rd_addr),
		.rr_addr (rr_addr),
		.wr      (reg_wr),
		.rd_data (rd_data),
		.rr_data (rr_data)
	);

endmodule

/* hw/avr_execute.sv */
module avr_execute (
	input  logic                CLK,
	input  logic                RST,
	input  avr_pkg::fetch_t     fetched,
	input  avr_pkg::byte_t      rd_data,
	input  avr_pkg::byte_t      rr_data,
	input  avr_pkg::byte_t      alu_result,
	input  avr_pkg::sreg_t      alu_sreg,
	output avr_pkg::reg_addr_t  rd_addr,
	output avr_pkg::reg_addr_t  rr_addr,
	output avr_pkg::alu_op_e    alu_op,
	output avr_pkg::byte_t      alu_a,
	output avr_pkg::byte_t      alu_b,
	output avr_pkg::sreg_t      sreg,
	output avr_pkg::reg_wr_t    reg_wr,
	output avr_pkg::redirect_t  redirect
);

	avr_pkg::instr_u ins;
	avr_pkg::byte_t k;
	avr_pkg::sreg_t sreg_q;
	avr_pkg::word_t offset;
	logic use_imm;
	logic wr_en;
	logic flag_en;
	logic is_branch;
	logic is_rjmp;
	logic br_taken;

	assign ins = fetched.instr;
	assign k = {ins.imm.k_hi, ins.imm.k_lo};

	always_comb begin
		alu_op = avr_pkg::ALU_PASS_B;
		use_imm = 1'b0;
		wr_en = 1'b0;
		flag_en = 1'b0;
		is_branch = 1'b0;
		is_rjmp = 1'b0;

		case (ins.imm.opcode)
			avr_pkg::OP_CPI: begin
				alu_op = avr_pkg::ALU_SUB;
				use_imm = 1'b1;
				flag_en = 1'b1; // Compare only, no write-back
			end
			avr_pkg::OP_SBCI: {alu_op, use_imm, wr_en, flag_en} = {avr_pkg::ALU_SBC, 3'b111};
			avr_pkg::OP_SUBI: {alu_op, use_imm, wr_en, flag_en} = {avr_pkg::ALU_SUB, 3'b111};
			avr_pkg::OP_ORI:  {alu_op, use_imm, wr_en, flag_en} = {avr_pkg::ALU_OR, 3'b111};
			avr_pkg::OP_ANDI: {alu_op, use_imm, wr_en, flag_en} = {avr_pkg::ALU_AND, 3'b111};
			avr_pkg::OP_LDI:  {alu_op, use_imm, wr_en} = {avr_pkg::ALU_PASS_B, 2'b11};
			avr_pkg::OP_RJMP: is_rjmp = 1'b1;
			avr_pkg::OP_BR_HI: is_branch = (ins.br.opcode == avr_pkg::OP_BRBX);
			default: begin
				// Two-register group
				case (ins.rf.opcode)
					avr_pkg::OP_ADD: {alu_op, wr_en, flag_en} = {avr_pkg::ALU_ADD, 2'b11};
					avr_pkg::OP_ADC: {alu_op, wr_en, flag_en} = {avr_pkg::ALU_ADC, 2'b11};
					avr_pkg::OP_SUB: {alu_op, wr_en, flag_en} = {avr_pkg::ALU_SUB, 2'b11};
					avr_pkg::OP_SBC: {alu_op, wr_en, flag_en} = {avr_pkg::ALU_SBC, 2'b11};
					avr_pkg::OP_AND: {alu_op, wr_en, flag_en} = {avr_pkg::ALU_AND, 2'b11};
					avr_pkg::OP_OR:  {alu_op, wr_en, flag_en} = {avr_pkg::ALU_OR, 2'b11};
					avr_pkg::OP_CP:  {alu_op, flag_en} = {avr_pkg::ALU_SUB, 1'b1};
					avr_pkg::OP_SWAP: begin
						if (!ins.rf.r_hi && ins.rf.r_lo == avr_pkg::SWAP_LO) begin
							alu_op = avr_pkg::ALU_SWAP;
							wr_en = 1'b1;
						end
					end
					default: alu_op = avr_pkg::ALU_PASS_B; // Anything else runs as NOP
				endcase
			end
		endcase
	end

	// Immediate forms only reach r16..r31
	assign rd_addr = use_imm ? {1'b1, ins.imm.d} : ins.rf.d;
	assign rr_addr = {ins.rf.r_hi, ins.rf.r_lo};
	assign alu_a = rd_data;
	assign alu_b = use_imm ? k : rr_data;

	// Set form branches on 1, clear form on 0
	assign br_taken = is_branch && (sreg_q[ins.br.sel] != ins.br.clear);
	assign offset = is_rjmp ? {{4{ins.jmp.offset[11]}}, ins.jmp.offset}
		: {{9{ins.br.offset[6]}}, ins.br.offset};

	assign redirect.done = fetched.valid;
	assign redirect.taken = fetched.valid && (is_rjmp || br_taken);
	assign redirect.target = fetched.pc + 16'd1 + offset;

	assign reg_wr.en = fetched.valid && wr_en;
	assign reg_wr.addr = rd_addr;
	assign reg_wr.data = alu_result;

	always_ff @(posedge CLK) begin
		if (RST) sreg_q <= '0;
		else if (fetched.valid && flag_en) sreg_q <= alu_sreg;
	end

	assign sreg = sreg_q;

endmodule

/* hw/avr_fetch.sv */
module avr_fetch #(
	parameter avr_pkg::word_t RESET_PC = '0
) (
	input  logic                CLK,
	input  logic                RST,
	input  avr_pkg::redirect_t  redirect,
	input  avr_pkg::wb_rsp_t    prog_rsp,
	output avr_pkg::wb_req_t    prog_req,
	output avr_pkg::fetch_t     fetched
);

	// One instruction in flight, so fetch just walks these three states
	typedef enum logic [1:0] {
		F_START,
		F_REQ,
		F_EXEC
	} state_e;

	state_e state;
	avr_pkg::word_t pc;
	avr_pkg::instr_u ir;

	always_ff @(posedge CLK) begin
		if (RST) begin
			state <= F_START;
			pc <= RESET_PC;
		end else begin
			case (state)
				F_START: state <= F_REQ;
				F_REQ: begin
					if (prog_rsp.ack) state <= F_EXEC; // End of the bus transfer
				end
				F_EXEC: begin
					if (redirect.done) begin
						state <= F_REQ;
						pc <= redirect.taken ? redirect.target : pc + 16'd1;
					end
				end
				default: state <= F_START;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge CLK) begin
		if (state == F_REQ && prog_rsp.ack) ir <= prog_rsp.dat;
	end

	// Wishbone classic read, adr held by pc until ack
	assign prog_req.cyc = (state == F_REQ);
	assign prog_req.stb = (state == F_REQ);
	assign prog_req.adr = pc;

	assign fetched.valid = (state == F_EXEC);
	assign fetched.instr = ir;
	assign fetched.pc = pc;

endmodule

/* hw/avr_pkg.sv */
package avr_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// Bit order matches the AVR SREG, C in bit 0
	typedef struct packed {
		logic i;
		logic t;
		logic h;
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} sreg_t;

	// Two-register ops, also SWAP (single operand in d)
	typedef struct packed {
		logic [5:0] opcode;
		logic       r_hi;
		logic [4:0] d;
		logic [3:0] r_lo;
	} instr_reg_t;

	// Register plus 8-bit constant, d counts from r16
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] k_hi;
		logic [3:0] d;
		logic [3:0] k_lo;
	} instr_imm_t;

	typedef struct packed {
		logic [4:0] opcode;
		logic       clear; // BRBC when set
		logic [6:0] offset;
		logic [2:0] sel;   // SREG bit under test
	} instr_br_t;

	typedef struct packed {
		logic [3:0]  opcode;
		logic [11:0] offset;
	} instr_jmp_t;

	typedef union packed {
		instr_reg_t rf;
		instr_imm_t imm;
		instr_br_t  br;
		instr_jmp_t jmp;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_SWAP,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic   valid;
		instr_u instr;
		word_t  pc;
	} fetch_t;

	typedef struct packed {
		logic  done;
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		byte_t     data;
	} reg_wr_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		word_t adr;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	// Register form, top six bits
	localparam logic [5:0] OP_ADD  = 6'b000011;
	localparam logic [5:0] OP_ADC  = 6'b000111;
	localparam logic [5:0] OP_SUB  = 6'b000110;
	localparam logic [5:0] OP_SBC  = 6'b000010;
	localparam logic [5:0] OP_AND  = 6'b001000;
	localparam logic [5:0] OP_OR   = 6'b001010;
	localparam logic [5:0] OP_CP   = 6'b000101;
	localparam logic [5:0] OP_SWAP = 6'b100101;
	localparam logic [3:0] SWAP_LO = 4'b0010; // Low nibble that picks SWAP out of its group

	// Immediate and jump forms, top four bits
	localparam logic [3:0] OP_CPI  = 4'b0011;
	localparam logic [3:0] OP_SBCI = 4'b0100;
	localparam logic [3:0] OP_SUBI = 4'b0101;
	localparam logic [3:0] OP_ORI  = 4'b0110;
	localparam logic [3:0] OP_ANDI = 4'b0111;
	localparam logic [3:0] OP_LDI  = 4'b1110;
	localparam logic [3:0] OP_RJMP = 4'b1100;
	localparam logic [3:0] OP_BR_HI = 4'b1111;
	localparam logic [4:0] OP_BRBX = 5'b11110;

endpackage

/* hw/avr_regfile.sv */
module avr_regfile (
	input  logic                CLK,
	input  logic                RST,
	input  avr_pkg::reg_addr_t  rd_addr,
	input  avr_pkg::reg_addr_t  rr_addr,
	input  avr_pkg::reg_wr_t    wr,
	output avr_pkg::byte_t      rd_data,
	output avr_pkg::byte_t      rr_data
);

	avr_pkg::byte_t regs [32];

	// Single write port, r0..r31
	always_ff @(posedge CLK) begin
		if (RST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Reads are asynchronous so execute finishes in its single cycle
	assign rd_data = regs[rd_addr];
	assign rr_data = regs[rr_addr];

endmodule

/* sources.f */
hw/avr_pkg.sv
hw/avr_regfile.sv
hw/avr_alu.sv
hw/avr_fetch.sv
hw/avr_execute.sv
hw/avr_core.sv
test/tb_avr_core.sv

/* test/tb_avr_core.sv */
module tb_avr_core;

	localparam avr_pkg::word_t RESET_PC = 16'h0000;
	localparam int PROG_LEN = 40;
	localparam int CYCLE_LIMIT = PROG_LEN * 6 + 100;
	localparam logic [15:0] HALT_WORD = 16'hCFFF; // RJMP to itself

	// Reference model operation classes
	localparam int K_NONE = 0;
	localparam int K_ADD = 1;
	localparam int K_SUB = 2;
	localparam int K_AND = 3;
	localparam int K_OR = 4;
	localparam int K_SWAP = 5;
	localparam int K_LOAD = 6;

	logic CLK;
	logic RST;
	avr_pkg::wb_rsp_t prog_rsp;
	avr_pkg::wb_req_t prog_req;
	avr_pkg::reg_wr_t reg_wr;
	avr_pkg::sreg_t sreg;

	logic [15:0] prog [PROG_LEN];
	logic [7:0] mregs [32];
	logic [7:0] msreg; // Same bit order as SREG, C in bit 0
	logic [15:0] mpc;
	logic exp_en;
	logic [4:0] exp_addr;
	logic [7:0] exp_data;
	logic pending = 1'b0;
	logic halted = 1'b0;
	logic hold_wait = 1'b0;
	logic [15:0] hold_adr;
	int cycles = 0;
	int value_errs = 0;
	int other_errs = 0;

	avr_core #(
		.RESET_PC (RESET_PC)
	) dut_i (
		.CLK      (CLK),
		.RST      (RST),
		.prog_rsp (prog_rsp),
		.prog_req (prog_req),
		.reg_wr   (reg_wr),
		.sreg     (sreg)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic fail_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		value_errs++;
	endtask

	task automatic fail_msg(input string what);
		$display("Error at %0t: %s", $time, what);
		other_errs++;
	endtask

	function automatic logic [15:0] enc_reg(input logic [5:0] op, input logic [4:0] d,
		input logic [4:0] r);
		return {op, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [4:0] d,
		input logic [7:0] k);
		return {op, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_branch(input logic clear, input logic [6:0] off,
		input logic [2:0] bit_sel);
		return {5'b11110, clear, off, bit_sel};
	endfunction

	function automatic logic [15:0] fetch_word(input logic [15:0] adr);
		return (adr < 16'd40) ? prog[adr[5:0]] : 16'h0000; // NOP past the end
	endfunction

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = 16'h0000;
		end
		prog[0] = enc_imm(4'hE, 5'd16, 8'h0F);      // LDI r16
		prog[1] = enc_imm(4'hE, 5'd17, 8'h01);
		prog[2] = enc_reg(6'b000011, 5'd16, 5'd17); // ADD, half carry
		prog[3] = enc_imm(4'hE, 5'd18, 8'h7F);
		prog[4] = enc_reg(6'b000011, 5'd18, 5'd17); // ADD, signed overflow
		prog[5] = enc_imm(4'hE, 5'd19, 8'hFF);
		prog[6] = enc_reg(6'b000011, 5'd19, 5'd17); // ADD, carry and zero
		prog[7] = enc_reg(6'b000111, 5'd0, 5'd16);  // ADC with C set
		prog[8] = enc_reg(6'b000110, 5'd0, 5'd17);  // SUB
		prog[9] = enc_imm(4'hE, 5'd20, 8'h20);
		prog[10] = enc_reg(6'b000110, 5'd17, 5'd20); // SUB with borrow
		prog[11] = enc_reg(6'b000010, 5'd1, 5'd20);  // SBC
		prog[12] = enc_reg(6'b001000, 5'd0, 5'd18);  // AND
		prog[13] = enc_reg(6'b001010, 5'd1, 5'd16);  // OR
		prog[14] = {7'b1001010, 5'd1, 4'b0010};      // SWAP r1
		prog[15] = enc_imm(4'h5, 5'd16, 8'h10);      // SUBI
		prog[16] = enc_imm(4'h4, 5'd19, 8'h01);      // SBCI
		prog[17] = enc_imm(4'h7, 5'd18, 8'hF0);      // ANDI
		prog[18] = enc_imm(4'h6, 5'd20, 8'h05);      // ORI
		prog[19] = enc_reg(6'b000101, 5'd17, 5'd20); // CP
		prog[20] = enc_imm(4'h3, 5'd21, 8'h00);      // CPI, Z set and C clear
		prog[21] = enc_branch(1'b0, 7'd1, 3'd1);     // BREQ taken
		prog[22] = enc_imm(4'hE, 5'd22, 8'hAA);
		prog[23] = enc_branch(1'b1, 7'd1, 3'd1);     // BRNE not taken
		prog[24] = enc_branch(1'b1, 7'd2, 3'd0);     // BRCC taken
		prog[25] = enc_imm(4'hE, 5'd23, 8'h55);
		prog[26] = enc_imm(4'hE, 5'd23, 8'h66);
		prog[27] = enc_branch(1'b0, 7'd5, 3'd0);     // BRCS not taken
		prog[28] = enc_branch(1'b0, 7'd3, 3'd6);     // BRTS, T never set
		prog[29] = {4'b1100, 12'd3};                 // RJMP forward
		prog[30] = enc_imm(4'hE, 5'd24, 8'h11);
		prog[31] = enc_branch(1'b1, 7'd2, 3'd7);     // BRID taken
		prog[32] = enc_imm(4'hE, 5'd25, 8'h99);
		prog[33] = {4'b1100, 12'hFFC};               // RJMP back to 30
		prog[34] = enc_reg(6'b000011, 5'd31, 5'd1);
		prog[35] = 16'h0000;                         // NOP
		prog[36] = 16'h9508;                         // RET, unsupported so NOP
		prog[37] = enc_imm(4'h3, 5'd31, 8'hFD);
		prog[38] = HALT_WORD;
	endtask

	// Executes one instruction on the model state
	task automatic model_step(input logic [15:0] w);
		int kind;
		logic imm;
		logic with_c;
		logic wb;
		logic cin;
		logic [4:0] d;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] r;
		logic [8:0] full;
		logic [4:0] nib;
		logic [15:0] next_pc;

		kind = K_NONE;
		imm = 1'b0;
		with_c = 1'b0;
		wb = 1'b1;
		next_pc = mpc + 16'd1;
		casez (w)
			16'b0000_11??_????_????: kind = K_ADD;
			16'b0001_11??_????_????: {kind, with_c} = {K_ADD, 1'b1};
			16'b0001_10??_????_????: kind = K_SUB;
			16'b0000_10??_????_????: {kind, with_c} = {K_SUB, 1'b1};
			16'b0001_01??_????_????: {kind, wb} = {K_SUB, 1'b0}; // CP
			16'b0010_00??_????_????: kind = K_AND;
			16'b0010_10??_????_????: kind = K_OR;
			16'b1001_010?_????_0010: kind = K_SWAP;
			16'b0011_????_????_????: {kind, imm, wb} = {K_SUB, 2'b10};
			16'b0100_????_????_????: {kind, imm, with_c} = {K_SUB, 2'b11};
			16'b0101_????_????_????: {kind, imm} = {K_SUB, 1'b1};
			16'b0110_????_????_????: {kind, imm} = {K_OR, 1'b1};
			16'b0111_????_????_????: {kind, imm} = {K_AND, 1'b1};
			16'b1110_????_????_????: {kind, imm} = {K_LOAD, 1'b1};
			16'b1100_????_????_????: next_pc = mpc + 16'd1 + {{4{w[11]}}, w[11:0]};
			16'b1111_0???_????_????: begin
				if (msreg[w[2:0]] != w[10]) next_pc = mpc + 16'd1 + {{9{w[9]}}, w[9:3]};
			end
			default: ;
		endcase

		d = imm ? {1'b1, w[7:4]} : w[8:4];
		a = mregs[d];
		b = imm ? {w[11:8], w[3:0]} : mregs[{w[9], w[3:0]}];
		cin = with_c & msreg[0];
		r = b;
		case (kind)
			K_ADD: begin
				full = {1'b0, a} + {1'b0, b} + {8'd0, cin};
				nib = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
				r = full[7:0];
				msreg[5] = nib[4];
				msreg[3] = (a[7] == b[7]) && (r[7] != a[7]);
				msreg[0] = full[8];
			end
			K_SUB: begin
				full = {1'b0, a} - {1'b0, b} - {8'd0, cin};
				nib = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
				r = full[7:0];
				msreg[5] = nib[4]; // Borrow out of bit 3
				msreg[3] = (a[7] != b[7]) && (r[7] != a[7]);
				msreg[0] = full[8];
			end
			K_AND: {r, msreg[3]} = {a & b, 1'b0};
			K_OR: {r, msreg[3]} = {a | b, 1'b0};
			K_SWAP: r = {a[3:0], a[7:4]};
			default: ;
		endcase
		if (kind >= K_ADD && kind <= K_OR) begin
			msreg[2] = r[7];
			msreg[1] = (r == 8'd0);
			msreg[4] = r[7] ^ msreg[3];
		end

		exp_en = (kind != K_NONE) && wb;
		exp_addr = d;
		exp_data = r;
		if (exp_en) mregs[d] = r;
		mpc = next_pc;
	endtask

	// Program memory slave, 0 to 3 wait states per read
	initial begin
		logic busy;
		int wait_left;

		void'($urandom(57889));
		busy = 1'b0;
		wait_left = 0;
		prog_rsp = '0;
		forever begin
			@(posedge CLK);
			#1;
			if (prog_rsp.ack) begin
				prog_rsp.ack = 1'b0;
				busy = 1'b0;
			end else if (prog_req.cyc && prog_req.stb) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = $urandom % 4;
				end
				if (wait_left == 0) begin
					prog_rsp.ack = 1'b1;
					prog_rsp.dat = fetch_word(prog_req.adr);
				end else begin
					wait_left--;
				end
			end
		end
	end

	always @(posedge CLK) begin
		if (!RST) cycles++;
	end

	// Outputs sampled mid-cycle
	always @(negedge CLK) begin
		assert (prog_req.cyc == prog_req.stb) else fail_msg("cyc and stb differ");
		if (RST || cycles == 0) begin
			assert (!prog_req.cyc) else fail_msg("bus request during reset");
			assert (!reg_wr.en) else fail_msg("register write during reset");
		end else begin
			if (cycles == 1) begin
				assert (prog_req.cyc) else fail_msg("no request in the first cycle after reset");
				assert (prog_req.adr == RESET_PC)
					else fail_value("prog_req.adr", prog_req.adr, RESET_PC);
			end
			if (hold_wait) begin
				assert (prog_req.cyc) else fail_msg("request dropped before ack");
				assert (prog_req.adr == hold_adr)
					else fail_value("prog_req.adr", prog_req.adr, hold_adr);
			end
			if (pending) begin
				pending = 1'b0;
				assert (reg_wr.en == exp_en)
					else fail_value("reg_wr.en", 16'(reg_wr.en), 16'(exp_en));
				if (exp_en) begin
					assert (reg_wr.addr == exp_addr)
						else fail_value("reg_wr.addr", 16'(reg_wr.addr), 16'(exp_addr));
					assert (reg_wr.data == exp_data)
						else fail_value("reg_wr.data", 16'(reg_wr.data), 16'(exp_data));
				end
			end else begin
				assert (!reg_wr.en) else fail_msg("register write outside an execute cycle");
			end
			if (prog_rsp.ack) begin
				// Flags of the previous instruction and the next PC
				assert (sreg == msreg) else fail_value("sreg", 16'(sreg), 16'(msreg));
				assert (prog_req.adr == mpc) else fail_value("prog_req.adr", prog_req.adr, mpc);
				model_step(prog_rsp.dat);
				pending = 1'b1;
				if (prog_rsp.dat == HALT_WORD) halted = 1'b1;
			end
			hold_wait = prog_req.cyc && prog_req.stb && !prog_rsp.ack;
			hold_adr = prog_req.adr;
		end
	end

	initial begin
		RST = 1'b1;
		msreg = 8'h00;
		mpc = RESET_PC;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = 8'h00;
		end
		load_program();
		repeat (16) @(posedge CLK);
		#1 RST = 1'b0;

		while (!halted && cycles < CYCLE_LIMIT) @(posedge CLK);
		if (!halted) begin
			fail_msg("timeout, the core never reached the halt loop");
		end else begin
			repeat (2) @(negedge CLK); // Let the last write-back check run
			@(posedge CLK);
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
